/* source/paging_defines.svh */
`ifndef PAGING_DEFINES_SVH
`define PAGING_DEFINES_SVH

// paging port addresses
`define PORT_7FFD       16'h7FFD
`define PORT_EFF7       16'hEFF7
`define PORT_77_LOW     8'h77
`define PAGER_PORT_LOW  8'hF7
// bits 13..8 of a window pager port, window number sits in 15..14
`define PAGER_PORT_MID  6'h3F

// address and page widths
`define PHYS_ADDR_W     21
`define WIN_ADDR_W      14
`define RAM_PAGE_W      7
`define ROM_PAGE_W      5
`define N_WINDOWS       4

// fixed pentagon pages and the dos trap
`define DOS_TRAP_HI     8'h3D
`define PENT_WIN1_PAGE  7'd5
`define PENT_WIN2_PAGE  7'd2

`endif

/* source/z80_bus_pkg.sv */
`include "paging_defines.svh"

package z80_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// z80 side transactions
	////////////////////////////////////////////////////////////////////////////

	// one i/o write cycle
	typedef struct packed
	{
		logic [15:0] port;
		logic [7:0]  data;
	} io_wr_t;

	// one memory access, m1 marks an opcode fetch
	typedef struct packed
	{
		logic [15:0] addr;
		logic        m1;
	} mem_req_t;

	// translated access as seen by the memory side
	typedef struct packed
	{
		logic                    is_ram;
		logic [`PHYS_ADDR_W-1:0] phys_addr;
	} mapped_t;

endpackage

/* source/paging_pkg.sv */
`include "paging_defines.svh"

package paging_pkg;

	////////////////////////////////////////////////////////////////////////////
	// page entry, one byte per window
	////////////////////////////////////////////////////////////////////////////

	// ram page view
	typedef struct packed
	{
		logic                   is_ram;
		logic [`RAM_PAGE_W-1:0] ram_page;
	} ram_view_t;

	// rom page view, top page bits unused
	typedef struct packed
	{
		logic                               is_ram;
		logic [`RAM_PAGE_W-`ROM_PAGE_W-1:0] unused;
		logic [`ROM_PAGE_W-1:0]             rom_page;
	} rom_view_t;

	// bit 7 tells which view applies
	typedef union packed
	{
		ram_view_t ram;
		rom_view_t rom;
	} page_entry_u;

	////////////////////////////////////////////////////////////////////////////
	// pentagon registers
	////////////////////////////////////////////////////////////////////////////

	// p7ffd: 7..6 and 2..0 ram page, 4 rom select, 5 lock
	// eff7: bit 3 maps ram page 0 into window 0
	typedef struct packed
	{
		logic [7:0] p7ffd;
		logic [7:0] eff7;
	} pent_state_t;

endpackage

/* source/port_decoder.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module port_decoder
	import z80_bus_pkg::*;
(
	input  logic                  fclk,
	input  logic                  reset,

	input  logic                  io_wr_stb,
	input  io_wr_t                io_wr,

	output logic                  wr_7ffd,
	output logic                  wr_eff7,
	output logic [`N_WINDOWS-1:0] wr_page,
	output logic                  pager_on
);

	logic       hit_7ffd;
	logic       hit_eff7;
	logic       hit_77;
	logic       hit_pager;
	logic [1:0] win_sel;

	////////////////////////////////////////////////////////////////////////////
	// address compare
	////////////////////////////////////////////////////////////////////////////

	// full 16-bit decode for the pentagon ports
	assign hit_7ffd = (io_wr.port == `PORT_7FFD);
	assign hit_eff7 = (io_wr.port == `PORT_EFF7);

	// port 77 only looks at the low byte
	assign hit_77 = (io_wr.port[7:0] == `PORT_77_LOW);

	// xxF7 with bits 13..8 all set is a window pager port
	assign hit_pager = (io_wr.port[7:0] == `PAGER_PORT_LOW) &&
		(io_wr.port[13:8] == `PAGER_PORT_MID);

	assign win_sel = io_wr.port[15:14];

	////////////////////////////////////////////////////////////////////////////
	// write strobes, one cycle with io_wr_stb
	////////////////////////////////////////////////////////////////////////////

	assign wr_7ffd = io_wr_stb && hit_7ffd;
	assign wr_eff7 = io_wr_stb && hit_eff7;

	always_comb
	begin
		for (int w = 0; w < `N_WINDOWS; w++)
		begin
			wr_page[w] = io_wr_stb && hit_pager && (win_sel == 2'(w));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// paging scheme select
	////////////////////////////////////////////////////////////////////////////

	// 0 pentagon, 1 atm windows
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pager_on <= 1'b0;
		end
		else if (io_wr_stb && hit_77)
		begin
			pager_on <= io_wr.data[0];
		end
	end

endmodule

/* source/pent_regs.sv */
`timescale 1ns/100ps

module pent_regs
	import paging_pkg::*;
(
	input  logic        fclk,
	input  logic        reset,

	input  logic        wr_7ffd,
	input  logic        wr_eff7,
	input  logic [7:0]  data,

	output pent_state_t pent
);

	logic lock;

	// bit 5 freezes 7ffd until reset
	assign lock = pent.p7ffd[5];

	// 7ffd
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pent.p7ffd <= 8'h00;
		end
		else if (wr_7ffd && !lock)
		begin
			pent.p7ffd <= data;
		end
	end

	// eff7, never locked
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pent.eff7 <= 8'h00;
		end
		else if (wr_eff7)
		begin
			pent.eff7 <= data;
		end
	end

endmodule

/* source/window_pager.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module window_pager
	import paging_pkg::*;
#(
	parameter int WINDOW = 0
)
(
	input  logic        fclk,
	input  logic        reset,

	input  logic        wr_page,
	input  logic [7:0]  data,

	input  logic        pager_on,
	input  pent_state_t pent,
	input  logic        dos,

	output page_entry_u entry
);

	page_entry_u atm_page;
	page_entry_u pent_page;

	// atm page byte for this window
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			atm_page <= '0;
		end
		else if (wr_page)
		begin
			atm_page <= data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pentagon mapping of this window
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		pent_page = '0;
		case (WINDOW)
			0:
			begin
				if (pent.eff7[3])
				begin
					// ram page 0 over the rom
					pent_page.ram.is_ram = 1'b1;
				end
				else
				begin
					pent_page.rom.rom_page = {3'b000, dos, pent.p7ffd[4]};
				end
			end
			1:
			begin
				pent_page.ram.is_ram   = 1'b1;
				pent_page.ram.ram_page = `PENT_WIN1_PAGE;
			end
			2:
			begin
				pent_page.ram.is_ram   = 1'b1;
				pent_page.ram.ram_page = `PENT_WIN2_PAGE;
			end
			default:
			begin
				// 128k page plus the two extended bits
				pent_page.ram.is_ram   = 1'b1;
				pent_page.ram.ram_page = {2'b00, pent.p7ffd[7:6], pent.p7ffd[2:0]};
			end
		endcase
	end

	assign entry = pager_on ? atm_page : pent_page;

endmodule

/* source/dos_tracker.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module dos_tracker
	import z80_bus_pkg::*, paging_pkg::*;
(
	input  logic        fclk,
	input  logic        reset,

	input  logic        mem_stb,
	input  mem_req_t    mem_req,

	input  page_entry_u win0,
	input  logic        rom_sel,

	output logic        dos
);

	logic fetch;
	logic trap_hit;
	logic exit_hit;

	assign fetch = mem_stb && mem_req.m1;

	// opcode fetch at 3Dxx from the basic rom
	assign trap_hit = fetch && (mem_req.addr[15:8] == `DOS_TRAP_HI) &&
		!win0.rom.is_ram && rom_sel;

	// any opcode fetch outside window 0
	assign exit_hit = fetch && (mem_req.addr[15:`WIN_ADDR_W] != '0);

	// the triggering fetch itself still sees the old flag
	always_ff @(posedge fclk)
	begin
		if (reset)
			dos <= 1'b0;
		else if (trap_hit)
			dos <= 1'b1;
		else if (exit_hit)
			dos <= 1'b0;
	end

endmodule

/* source/addr_mapper.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module addr_mapper
	import z80_bus_pkg::*, paging_pkg::*;
(
	input  logic                             fclk,
	input  logic                             reset,

	input  logic                             mem_stb,
	input  mem_req_t                         mem_req,

	input  page_entry_u [`N_WINDOWS-1:0]     entries,

	output logic                             mapped_valid,
	output mapped_t                          mapped
);

	logic [1:0]              win;
	page_entry_u             sel;
	logic [`PHYS_ADDR_W-1:0] phys;

	////////////////////////////////////////////////////////////////////////////
	// window select and address build
	////////////////////////////////////////////////////////////////////////////

	assign win = mem_req.addr[15:`WIN_ADDR_W];
	assign sel = entries[win];

	always_comb
	begin
		if (sel.ram.is_ram)
			phys = {sel.ram.ram_page, mem_req.addr[`WIN_ADDR_W-1:0]};
		else
			phys = {{(`PHYS_ADDR_W-`ROM_PAGE_W-`WIN_ADDR_W){1'b0}},
				sel.rom.rom_page, mem_req.addr[`WIN_ADDR_W-1:0]};
	end

	////////////////////////////////////////////////////////////////////////////
	// output stage, one result per strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
			mapped_valid <= 1'b0;
		else
			mapped_valid <= mem_stb;
	end

	// payload only moves with a request
	always_ff @(posedge fclk)
	begin
		if (mem_stb)
		begin
			mapped.is_ram    <= sel.ram.is_ram;
			mapped.phys_addr <= phys;
		end
	end

endmodule

/* source/paging_top.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module paging_top
	import z80_bus_pkg::*, paging_pkg::*;
(
	input  logic     fclk,
	input  logic     reset,

	input  logic     io_wr_stb,
	input  io_wr_t   io_wr,

	input  logic     mem_stb,
	input  mem_req_t mem_req,

	output logic     mapped_valid,
	output mapped_t  mapped,
	output logic     dos
);

	logic                          wr_7ffd;
	logic                          wr_eff7;
	logic [`N_WINDOWS-1:0]         wr_page;
	logic                          pager_on;
	pent_state_t                   pent;
	page_entry_u [`N_WINDOWS-1:0]  entries;

	port_decoder i_port_decoder (
		.fclk      (fclk),
		.reset     (reset),
		.io_wr_stb (io_wr_stb),
		.io_wr     (io_wr),
		.wr_7ffd   (wr_7ffd),
		.wr_eff7   (wr_eff7),
		.wr_page   (wr_page),
		.pager_on  (pager_on)
	);

	pent_regs i_pent_regs (
		.fclk    (fclk),
		.reset   (reset),
		.wr_7ffd (wr_7ffd),
		.wr_eff7 (wr_eff7),
		.data    (io_wr.data),
		.pent    (pent)
	);

	////////////////////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `N_WINDOWS; i++)
	begin : g_win
		window_pager #(.WINDOW(i)) i_window_pager (
			.fclk     (fclk),
			.reset    (reset),
			.wr_page  (wr_page[i]),
			.data     (io_wr.data),
			.pager_on (pager_on),
			.pent     (pent),
			.dos      (dos),
			.entry    (entries[i])
		);
	end

	// rom select is 7ffd bit 4
	dos_tracker i_dos_tracker (
		.fclk    (fclk),
		.reset   (reset),
		.mem_stb (mem_stb),
		.mem_req (mem_req),
		.win0    (entries[0]),
		.rom_sel (pent.p7ffd[4]),
		.dos     (dos)
	);

	addr_mapper i_addr_mapper (
		.fclk         (fclk),
		.reset        (reset),
		.mem_stb      (mem_stb),
		.mem_req      (mem_req),
		.entries      (entries),
		.mapped_valid (mapped_valid),
		.mapped       (mapped)
	);

endmodule

/* bench/paging_chk.sv */
`timescale 1ns/100ps

module paging_chk
(
	input logic fclk,
	input logic reset,
	input logic mem_stb,
	input logic mapped_valid,
	input logic dos
);

	// failed assertions seen so far
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// mapper timing
	////////////////////////////////////////////////////////////////////////////

	// one result per request exactly one cycle later
	valid_after_stb: assert property (@(posedge fclk) disable iff (reset)
		mem_stb |=> mapped_valid)
		else
		begin
			$error("mapped_valid missing one cycle after mem_stb");
			fail_count++;
		end

	no_stray_valid: assert property (@(posedge fclk) disable iff (reset)
		!mem_stb |=> !mapped_valid)
		else
		begin
			$error("mapped_valid without a mem_stb the cycle before");
			fail_count++;
		end

	valid_low_in_reset: assert property (@(posedge fclk)
		reset |=> !mapped_valid)
		else
		begin
			$error("mapped_valid high during reset");
			fail_count++;
		end

	// dos only moves on a memory access
	dos_needs_access: assert property (@(posedge fclk) disable iff (reset)
		!mem_stb |=> $stable(dos))
		else
		begin
			$error("dos changed without a memory access");
			fail_count++;
		end

endmodule

bind paging_top paging_chk i_chk (
	.fclk         (fclk),
	.reset        (reset),
	.mem_stb      (mem_stb),
	.mapped_valid (mapped_valid),
	.dos          (dos)
);

/* bench/paging_tb.sv */
`timescale 1ns/100ps
`include "paging_defines.svh"

module paging_tb
	import z80_bus_pkg::*;
();

	localparam int DRV_DLY  = 2;
	localparam int WAIT_MAX = 8;

	// step kinds
	localparam int IO_WR = 0;
	localparam int FETCH = 1;
	localparam int READ  = 2;

	typedef struct
	{
		string                   name;
		int                      kind;
		logic [15:0]             addr;
		logic [7:0]              data;
		logic                    is_ram;
		logic [`PHYS_ADDR_W-1:0] phys;
		logic                    dos;
	} step_t;

	logic        fclk;
	logic        reset;
	logic        io_wr_stb;
	io_wr_t      io_wr;
	logic        mem_stb;
	mem_req_t    mem_req;
	logic        mapped_valid;
	mapped_t     mapped;
	logic        dos;

	step_t       steps[$];
	int unsigned lcg_state;

	paging_top i_dut (
		.fclk         (fclk),
		.reset        (reset),
		.io_wr_stb    (io_wr_stb),
		.io_wr        (io_wr),
		.mem_stb      (mem_stb),
		.mem_req      (mem_req),
		.mapped_valid (mapped_valid),
		.mapped       (mapped),
		.dos          (dos)
	);

	always #10 fclk = ~fclk;

	////////////////////////////////////////////////////////////////////////////
	// expected address forms
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [`PHYS_ADDR_W-1:0] ram_addr(int page, logic [15:0] a);
		return {7'(page), a[13:0]};
	endfunction

	function automatic logic [`PHYS_ADDR_W-1:0] rom_addr(int page, logic [15:0] a);
		return {2'b00, 5'(page), a[13:0]};
	endfunction

	// lcg with the constants of the usual C library generator
	function int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic io_step(string name, logic [15:0] port, logic [7:0] data);
		step_t s;
		s.name = name;
		s.kind = IO_WR;
		s.addr = port;
		s.data = data;
		steps.push_back(s);
	endtask

	task automatic acc_step(string name, int kind, logic [15:0] addr, logic is_ram,
		logic [`PHYS_ADDR_W-1:0] phys, logic dos_exp);
		step_t s;
		s.name   = name;
		s.kind   = kind;
		s.addr   = addr;
		s.data   = 8'h00;
		s.is_ram = is_ram;
		s.phys   = phys;
		s.dos    = dos_exp;
		steps.push_back(s);
	endtask

	task automatic report_mismatch(string name, string field, logic [31:0] exp,
		logic [31:0] act);
		$display("CHECK FAILED %s %s expected %0h actual %0h", name, field, exp, act);
		$display("SOME TESTS FAILED");
		$fatal(1, "mismatch at step %s", name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		logic [15:0] a;
		string       nm;
		// pentagon state right after reset
		acc_step("rst w0", READ, 16'h1234, 1'b0, rom_addr(0, 16'h1234), 1'b0);
		acc_step("rst w1", READ, 16'h5678, 1'b1, ram_addr(5, 16'h5678), 1'b0);
		acc_step("rst w2", READ, 16'h9ABC, 1'b1, ram_addr(2, 16'h9ABC), 1'b0);
		acc_step("rst w3", READ, 16'hC000, 1'b1, ram_addr(0, 16'hC000), 1'b0);
		for (int k = 0; k < 8; k++)
		begin
			a  = 16'(lcg_next() >> 16);
			nm = $sformatf("rnd rd %0d", k);
			case (a[15:14])
				2'd0: acc_step(nm, READ, a, 1'b0, rom_addr(0, a), 1'b0);
				2'd1: acc_step(nm, READ, a, 1'b1, ram_addr(5, a), 1'b0);
				2'd2: acc_step(nm, READ, a, 1'b1, ram_addr(2, a), 1'b0);
				default: acc_step(nm, READ, a, 1'b1, ram_addr(0, a), 1'b0);
			endcase
		end
		// no trap while the 128k rom is selected
		acc_step("no trap rom0", FETCH, 16'h3D00, 1'b0, rom_addr(0, 16'h3D00), 1'b0);
		// 7ffd page select and then the lock
		io_step("7ffd pg 30", 16'h7FFD, 8'hD6);
		acc_step("w3 pg 30", READ, 16'hC123, 1'b1, ram_addr(30, 16'hC123), 1'b0);
		acc_step("rom 1", READ, 16'h0100, 1'b0, rom_addr(1, 16'h0100), 1'b0);
		io_step("7ffd lock", 16'h7FFD, 8'h31);
		acc_step("w3 pg 1", READ, 16'hFFFF, 1'b1, ram_addr(1, 16'hFFFF), 1'b0);
		io_step("7ffd locked", 16'h7FFD, 8'h07);
		acc_step("locked w3", READ, 16'hC000, 1'b1, ram_addr(1, 16'hC000), 1'b0);
		acc_step("locked rom", READ, 16'h2000, 1'b0, rom_addr(1, 16'h2000), 1'b0);
		// dos trap where the trigger fetch still maps with the old flag
		acc_step("trap fetch", FETCH, 16'h3D2F, 1'b0, rom_addr(1, 16'h3D2F), 1'b1);
		acc_step("dos rom", READ, 16'h0005, 1'b0, rom_addr(3, 16'h0005), 1'b1);
		acc_step("w1 read keeps", READ, 16'h6000, 1'b1, ram_addr(5, 16'h6000), 1'b1);
		acc_step("exit fetch", FETCH, 16'h8000, 1'b1, ram_addr(2, 16'h8000), 1'b0);
		acc_step("basic rom", READ, 16'h0005, 1'b0, rom_addr(1, 16'h0005), 1'b0);
		// ram over rom in window 0
		io_step("eff7 ram0", 16'hEFF7, 8'h08);
		acc_step("w0 ram0", READ, 16'h0ABC, 1'b1, ram_addr(0, 16'h0ABC), 1'b0);
		acc_step("no trap ram", FETCH, 16'h3D00, 1'b1, ram_addr(0, 16'h3D00), 1'b0);
		// atm windows
		io_step("atm on", 16'h0077, 8'h01);
		acc_step("atm rst pg", READ, 16'h4000, 1'b0, rom_addr(0, 16'h4000), 1'b0);
		io_step("w0 ram 3", 16'h3FF7, 8'h83);
		io_step("w1 rom 4", 16'h7FF7, 8'h04);
		io_step("w2 ram 127", 16'hBFF7, 8'hFF);
		io_step("w3 rom 31", 16'hFFF7, 8'h1F);
		acc_step("atm w0", READ, 16'h0010, 1'b1, ram_addr(3, 16'h0010), 1'b0);
		acc_step("atm w1", READ, 16'h4010, 1'b0, rom_addr(4, 16'h4010), 1'b0);
		acc_step("atm w2", READ, 16'h8010, 1'b1, ram_addr(127, 16'h8010), 1'b0);
		acc_step("atm w3", READ, 16'hC010, 1'b0, rom_addr(31, 16'hC010), 1'b0);
		io_step("w1 ram 64", 16'h7FF7, 8'hC0);
		acc_step("atm w1 new", READ, 16'h7FFF, 1'b1, ram_addr(64, 16'h7FFF), 1'b0);
		acc_step("atm w0 kept", READ, 16'h0010, 1'b1, ram_addr(3, 16'h0010), 1'b0);
		// back to pentagon
		io_step("atm off", 16'h0077, 8'h00);
		acc_step("pent w0", READ, 16'h0010, 1'b1, ram_addr(0, 16'h0010), 1'b0);
		acc_step("pent w1", READ, 16'h4010, 1'b1, ram_addr(5, 16'h4010), 1'b0);
		acc_step("pent w3", READ, 16'hC010, 1'b1, ram_addr(1, 16'hC010), 1'b0);
	endtask

	task automatic run_step(step_t s);
		int waited;
		@(posedge fclk);
		#DRV_DLY;
		if (s.kind == IO_WR)
		begin
			io_wr_stb  = 1'b1;
			io_wr.port = s.addr;
			io_wr.data = s.data;
		end
		else
		begin
			mem_stb      = 1'b1;
			mem_req.addr = s.addr;
			mem_req.m1   = (s.kind == FETCH);
		end
		@(posedge fclk);
		#DRV_DLY;
		io_wr_stb = 1'b0;
		mem_stb   = 1'b0;
		if (s.kind != IO_WR)
		begin
			waited = 0;
			while (!mapped_valid && waited < WAIT_MAX)
			begin
				@(posedge fclk);
				#DRV_DLY;
				waited++;
			end
			if (!mapped_valid)
			begin
				$display("timeout waiting for mapped_valid at step %s", s.name);
				$display("SOME TESTS FAILED");
				$fatal(1, "no mapped result");
			end
			else
			begin
				assert (mapped.is_ram == s.is_ram)
				else report_mismatch(s.name, "is_ram", 32'(s.is_ram), 32'(mapped.is_ram));
				assert (mapped.phys_addr == s.phys)
				else report_mismatch(s.name, "phys_addr", 32'(s.phys),
					32'(mapped.phys_addr));
				assert (dos == s.dos)
				else report_mismatch(s.name, "dos", 32'(s.dos), 32'(dos));
			end
		end
	endtask

	initial
	begin
		fclk      = 1'b0;
		reset     = 1'b1;
		io_wr_stb = 1'b0;
		io_wr     = '0;
		mem_stb   = 1'b0;
		mem_req   = '0;
		lcg_state = 32'd73781;
		build_table();
		repeat (4) @(posedge fclk);
		#DRV_DLY;
		reset = 1'b0;
		foreach (steps[i])
			run_step(steps[i]);
		// the bound checks of the last request settle two edges later
		repeat (2) @(posedge fclk);
		#DRV_DLY;
		if (i_dut.i_chk.fail_count == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("bound assertions failed %0d times", i_dut.i_chk.fail_count);
			$display("SOME TESTS FAILED");
			$fatal(1, "bound assertion failures");
		end
	end

endmodule

/* sim.f */
+incdir+source
source/z80_bus_pkg.sv
source/paging_pkg.sv
source/port_decoder.sv
source/pent_regs.sv
source/window_pager.sv
source/dos_tracker.sv
source/addr_mapper.sv
source/paging_top.sv
bench/paging_chk.sv
bench/paging_tb.sv

/* Bender.yml */
package:
  name: paging_core

sources:
  - include_dirs:
      - source
    files:
      - source/z80_bus_pkg.sv
      - source/paging_pkg.sv
      - source/port_decoder.sv
      - source/pent_regs.sv
      - source/window_pager.sv
      - source/dos_tracker.sv
      - source/addr_mapper.sv
      - source/paging_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/paging_chk.sv
      - bench/paging_tb.sv
